/* hdl/soc_pkg.sv */
package soc_pkg;

    //////////////////////////////////////////////////
    // Bus types
    //////////////////////////////////////////////////

    // Byte address, region in bits 15:12
    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  region_t;
    typedef logic [11:0] offset_t;

    // Master request, held stable until ack
    typedef struct packed {
        logic  stb;
        logic  we;
        addr_t addr;
        data_t wdata;
    } wb_req_t;

    // Slave response, ack is a one-cycle pulse
    typedef struct packed {
        logic  ack;
        data_t rdata;
    } wb_rsp_t;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    localparam region_t REGION_RAM  = 4'h0;
    localparam region_t REGION_VRAM = 4'h1;
    localparam region_t REGION_CNT  = 4'h2;

    // Read value for unmapped regions
    localparam data_t UNMAPPED_DATA = 32'hDEAD_BEEF;

    // Counter register offsets
    localparam offset_t CNT_OFS_COUNT = 12'h000;
    localparam offset_t CNT_OFS_CTRL  = 12'h004;

    // Video RAM bus port sequence
    typedef enum logic [1:0] {
        vram_idle,
        vram_read,
        vram_respond
    } vram_state_e;

endpackage

/* hdl/wb_intercon.sv */
`timescale 1ns/1ps

module wb_intercon (
    input  logic             clk50,
    input  logic             arst_n,
    input  soc_pkg::wb_req_t master_req,
    output soc_pkg::wb_rsp_t master_rsp,
    output soc_pkg::wb_req_t ram_req,
    output soc_pkg::wb_req_t vram_req,
    output soc_pkg::wb_req_t cnt_req,
    input  soc_pkg::wb_rsp_t ram_rsp,
    input  soc_pkg::wb_rsp_t vram_rsp,
    input  soc_pkg::wb_rsp_t cnt_rsp
);

    soc_pkg::region_t region;
    logic             sel_ram;
    logic             sel_vram;
    logic             sel_cnt;
    logic             sel_none;
    logic             dflt_ack;

    // Region decode from the high nibble
    assign region   = master_req.addr[15:12];
    assign sel_ram  = (region == soc_pkg::REGION_RAM);
    assign sel_vram = (region == soc_pkg::REGION_VRAM);
    assign sel_cnt  = (region == soc_pkg::REGION_CNT);
    assign sel_none = ~(sel_ram | sel_vram | sel_cnt);

    // Shared request fields, strobe only to the selected slave
    always_comb begin
        ram_req      = master_req;
        vram_req     = master_req;
        cnt_req      = master_req;
        ram_req.stb  = master_req.stb & sel_ram;
        vram_req.stb = master_req.stb & sel_vram;
        cnt_req.stb  = master_req.stb & sel_cnt;
    end

    // Default responder, writes are dropped
    always_ff @(posedge clk50 or negedge arst_n) begin
        if (!arst_n) begin
            dflt_ack <= 1'b0;
        end else begin
            dflt_ack <= master_req.stb & sel_none & ~dflt_ack;
        end
    end

    // Response mux
    always_comb begin
        case (region)
            soc_pkg::REGION_RAM:  master_rsp = ram_rsp;
            soc_pkg::REGION_VRAM: master_rsp = vram_rsp;
            soc_pkg::REGION_CNT:  master_rsp = cnt_rsp;
            default: begin
                master_rsp.ack   = dflt_ack;
                master_rsp.rdata = soc_pkg::UNMAPPED_DATA;
            end
        endcase
    end

endmodule

/* hdl/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic             clk50,
    input  logic             arst_n,
    input  soc_pkg::wb_req_t req,
    output soc_pkg::wb_rsp_t rsp
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    soc_pkg::data_t   mem [RAM_WORDS];
    soc_pkg::data_t   rdata_q;
    logic [IDX_W-1:0] idx;
    logic             ack_q;
    logic             access;

    // Word index from the byte address
    assign idx = req.addr[IDX_W+1:2];

    // A held strobe is served once, then skipped in the ack cycle
    assign access = req.stb & ~ack_q;

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    always_ff @(posedge clk50 or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk50) begin
        if (access) begin
            if (req.we) begin
                mem[idx] <= req.wdata;
            end
            rdata_q <= mem[idx];
        end
    end

    assign rsp.ack   = ack_q;
    assign rsp.rdata = rdata_q;

endmodule

/* hdl/vram_dual.sv */
`timescale 1ns/1ps

module vram_dual #(
    parameter int VRAM_WORDS = 1024
) (
    input  logic                          clk50,
    input  logic                          arst_n,
    input  soc_pkg::wb_req_t              req,
    output soc_pkg::wb_rsp_t              rsp,
    input  logic [$clog2(VRAM_WORDS)-1:0] scan_addr,
    output soc_pkg::data_t                scan_data
);

    localparam int IDX_W = $clog2(VRAM_WORDS);

    soc_pkg::data_t       mem [VRAM_WORDS];
    soc_pkg::vram_state_e state;
    soc_pkg::data_t       bus_rdata;
    soc_pkg::data_t       scan_q;
    logic [IDX_W-1:0]     bus_idx;

    assign bus_idx = req.addr[IDX_W+1:2];

    //////////////////////////////////////////////////
    // Bus port sequence
    //////////////////////////////////////////////////

    always_ff @(posedge clk50 or negedge arst_n) begin
        if (!arst_n) begin
            state <= soc_pkg::vram_idle;
        end else begin
            case (state)
                soc_pkg::vram_idle: begin
                    if (req.stb) begin
                        state <= soc_pkg::vram_read;
                    end
                end
                soc_pkg::vram_read: state <= soc_pkg::vram_respond;
                // Back to idle right after the ack cycle
                default: state <= soc_pkg::vram_idle;
            endcase
        end
    end

    // Write and read data capture in the read state
    always_ff @(posedge clk50) begin
        if (state == soc_pkg::vram_read) begin
            if (req.we) begin
                mem[bus_idx] <= req.wdata;
            end
            bus_rdata <= mem[bus_idx];
        end
    end

    assign rsp.ack   = (state == soc_pkg::vram_respond);
    assign rsp.rdata = bus_rdata;

    //////////////////////////////////////////////////
    // Scan port
    //////////////////////////////////////////////////

    // Display feed, one word per cycle
    always_ff @(posedge clk50 or negedge arst_n) begin
        if (!arst_n) begin
            scan_q <= '0;
        end else begin
            scan_q <= mem[scan_addr];
        end
    end

    assign scan_data = scan_q;

endmodule

/* hdl/tick_counter.sv */
`timescale 1ns/1ps

module tick_counter #(
    parameter int TICK_DIV = 4
) (
    input  logic             clk50,
    input  logic             arst_n,
    input  soc_pkg::wb_req_t req,
    output soc_pkg::wb_rsp_t rsp
);

    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICK_DIV - 1);

    logic [PRE_W-1:0] pre;
    soc_pkg::data_t   count;
    soc_pkg::data_t   rdata_q;
    soc_pkg::offset_t offset;
    logic             enable;
    logic             ack_q;
    logic             access;
    logic             tick;

    assign offset = req.addr[11:0];
    assign access = req.stb & ~ack_q;
    assign tick   = enable & (pre == PRE_LAST);

    always_ff @(posedge clk50 or negedge arst_n) begin
        if (!arst_n) begin
            ack_q  <= 1'b0;
            enable <= 1'b0;
            count  <= '0;
            pre    <= '0;
        end else begin
            ack_q <= access;
            // Prescaler restarts whenever the counter is stopped
            if (!enable || tick) begin
                pre <= '0;
            end else begin
                pre <= pre + 1'b1;
            end
            // Bus load wins over the tick
            if (access && req.we && offset == soc_pkg::CNT_OFS_COUNT) begin
                count <= req.wdata;
            end else if (tick) begin
                count <= count + 1'b1;
            end
            if (access && req.we && offset == soc_pkg::CNT_OFS_CTRL) begin
                enable <= req.wdata[0];
            end
        end
    end

    // Register read mux
    always_ff @(posedge clk50) begin
        if (access) begin
            case (offset)
                soc_pkg::CNT_OFS_COUNT: rdata_q <= count;
                soc_pkg::CNT_OFS_CTRL:  rdata_q <= {31'b0, enable};
                default:                rdata_q <= '0;
            endcase
        end
    end

    assign rsp.ack   = ack_q;
    assign rsp.rdata = rdata_q;

endmodule

/* hdl/simple_soc.sv */
`timescale 1ns/1ps

module simple_soc #(
    parameter int RAM_WORDS  = 1024,
    parameter int VRAM_WORDS = 1024,
    parameter int TICK_DIV   = 4
) (
    input  logic                          clk50,
    input  logic                          arst_n,
    input  soc_pkg::wb_req_t              master_req,
    output soc_pkg::wb_rsp_t              master_rsp,
    input  logic [$clog2(VRAM_WORDS)-1:0] scan_addr,
    output soc_pkg::data_t                scan_data
);

    //////////////////////////////////////////////////
    // Slave buses
    //////////////////////////////////////////////////

    soc_pkg::wb_req_t ram_req;
    soc_pkg::wb_req_t vram_req;
    soc_pkg::wb_req_t cnt_req;
    soc_pkg::wb_rsp_t ram_rsp;
    soc_pkg::wb_rsp_t vram_rsp;
    soc_pkg::wb_rsp_t cnt_rsp;

    wb_intercon u_intercon (
        .clk50      (clk50),
        .arst_n     (arst_n),
        .master_req (master_req),
        .master_rsp (master_rsp),
        .ram_req    (ram_req),
        .vram_req   (vram_req),
        .cnt_req    (cnt_req),
        .ram_rsp    (ram_rsp),
        .vram_rsp   (vram_rsp),
        .cnt_rsp    (cnt_rsp)
    );

    //////////////////////////////////////////////////
    // Slaves
    //////////////////////////////////////////////////

    wb_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .clk50  (clk50),
        .arst_n (arst_n),
        .req    (ram_req),
        .rsp    (ram_rsp)
    );

    // Scan port stands in for the display controller
    vram_dual #(
        .VRAM_WORDS (VRAM_WORDS)
    ) u_vram (
        .clk50     (clk50),
        .arst_n    (arst_n),
        .req       (vram_req),
        .rsp       (vram_rsp),
        .scan_addr (scan_addr),
        .scan_data (scan_data)
    );

    tick_counter #(
        .TICK_DIV (TICK_DIV)
    ) u_counter (
        .clk50  (clk50),
        .arst_n (arst_n),
        .req    (cnt_req),
        .rsp    (cnt_rsp)
    );

endmodule

/* dv/soc_assert.sv */
`timescale 1ns/1ps

module soc_assert (
    input logic             clk50,
    input logic             arst_n,
    input soc_pkg::wb_rsp_t master_rsp,
    input soc_pkg::wb_req_t ram_req,
    input soc_pkg::wb_req_t vram_req,
    input soc_pkg::wb_req_t cnt_req
);

    int assert_errors = 0;

    // One-cycle ack pulse
    ack_single: assert property (@(posedge clk50) disable iff (!arst_n)
        master_rsp.ack |=> !master_rsp.ack)
        else begin
            assert_errors++;
            $error("ack high in two consecutive cycles");
        end

    strobe_onehot: assert property (@(posedge clk50) disable iff (!arst_n)
        $onehot0({ram_req.stb, vram_req.stb, cnt_req.stb}))
        else begin
            assert_errors++;
            $error("more than one slave strobe high");
        end

    ack_in_reset: assert property (@(posedge clk50) !arst_n |-> !master_rsp.ack)
        else begin
            assert_errors++;
            $error("ack high during reset");
        end

endmodule

bind wb_intercon soc_assert u_assert (
    .clk50      (clk50),
    .arst_n     (arst_n),
    .master_rsp (master_rsp),
    .ram_req    (ram_req),
    .vram_req   (vram_req),
    .cnt_req    (cnt_req)
);

/* dv/soc_checker.sv */
`timescale 1ns/1ps

module soc_checker (
    input  logic             clk50,
    input  logic             arst_n,
    input  soc_pkg::wb_req_t master_req,
    input  soc_pkg::wb_rsp_t master_rsp,
    input  soc_pkg::data_t   scan_data,
    input  soc_pkg::data_t   exp_data,
    input  logic             exp_rise,
    input  logic             scan_chk,
    output int               mismatch_count,
    output int               spurious_count,
    output int               ack_count
);

    soc_pkg::data_t prev_count;
    logic           have_prev;

    //////////////////////////////////////////////////
    // Bus responses
    //////////////////////////////////////////////////

    always @(posedge clk50 or negedge arst_n) begin
        if (!arst_n) begin
            mismatch_count <= 0;
            spurious_count <= 0;
            ack_count      <= 0;
            have_prev      <= 1'b0;
            prev_count     <= '0;
        end else begin
            if (master_rsp.ack) begin
                ack_count <= ack_count + 1;
                if (!master_req.stb) begin
                    spurious_count <= spurious_count + 1;
                    $display("Ack at time %0t with no request pending", $time);
                end else if (!master_req.we && exp_rise) begin
                    // Counter must move forward
                    if (master_rsp.rdata < exp_data ||
                        (have_prev && master_rsp.rdata <= prev_count)) begin
                        mismatch_count <= mismatch_count + 1;
                        $display("Mismatch at time %0t: count %h read %h, floor %h, previous %h",
                                 $time, master_rsp.rdata, master_req.addr, exp_data, prev_count);
                    end
                    prev_count <= master_rsp.rdata;
                    have_prev  <= 1'b1;
                end else if (!master_req.we && master_rsp.rdata !== exp_data) begin
                    mismatch_count <= mismatch_count + 1;
                    $display("Mismatch at time %0t: read %h expected %h got %h",
                             $time, master_req.addr, exp_data, master_rsp.rdata);
                end
            end
            // Scan result one cycle after the address
            if (scan_chk && scan_data !== exp_data) begin
                mismatch_count <= mismatch_count + 1;
                $display("Mismatch at time %0t: scan data expected %h got %h",
                         $time, exp_data, scan_data);
            end
        end
    end

endmodule

/* dv/tb_simple_soc.sv */
`timescale 1ns/1ps

module tb_simple_soc;

    localparam int RAM_WORDS       = 1024;
    localparam int VRAM_WORDS      = 1024;
    localparam int TICK_DIV        = 4;
    localparam int SCAN_W          = $clog2(VRAM_WORDS);
    localparam int RESET_CYCLES    = 4;
    localparam int MAX_TESTS       = 64;
    localparam int CYCLES_PER_TEST = 30;

    // Operation codes of the test file
    localparam logic [31:0] OP_WRITE = 32'd1;
    localparam logic [31:0] OP_READ  = 32'd2;
    localparam logic [31:0] OP_SCAN  = 32'd3;
    localparam logic [31:0] OP_RISE  = 32'd4;

    logic              clk50;
    logic              arst_n;
    soc_pkg::wb_req_t  master_req;
    soc_pkg::wb_rsp_t  master_rsp;
    logic [SCAN_W-1:0] scan_addr;
    soc_pkg::data_t    scan_data;

    // Expected values handed to the checker
    soc_pkg::data_t    exp_data;
    logic              exp_rise;
    logic              scan_chk;

    int                mismatch_count;
    int                spurious_count;
    int                ack_count;
    int                access_count;
    int                timeout_count;
    int                other_errors;
    int                num_tests;
    int unsigned       seed;
    logic              tests_loaded;

    // Four words per test line
    logic [31:0]       test_mem [4*MAX_TESTS];

    simple_soc #(
        .RAM_WORDS  (RAM_WORDS),
        .VRAM_WORDS (VRAM_WORDS),
        .TICK_DIV   (TICK_DIV)
    ) UUT (
        .clk50      (clk50),
        .arst_n     (arst_n),
        .master_req (master_req),
        .master_rsp (master_rsp),
        .scan_addr  (scan_addr),
        .scan_data  (scan_data)
    );

    soc_checker u_checker (
        .clk50          (clk50),
        .arst_n         (arst_n),
        .master_req     (master_req),
        .master_rsp     (master_rsp),
        .scan_data      (scan_data),
        .exp_data       (exp_data),
        .exp_rise       (exp_rise),
        .scan_chk       (scan_chk),
        .mismatch_count (mismatch_count),
        .spurious_count (spurious_count),
        .ack_count      (ack_count)
    );

    initial begin
        clk50 = 1'b0;
        forever #10 clk50 = ~clk50;
    end

    //////////////////////////////////////////////////
    // Test file access
    //////////////////////////////////////////////////

    function automatic logic [31:0] test_field(input logic [5:0] test, input logic [1:0] col);
        return test_mem[{test, col}];
    endfunction

    function automatic logic known_op(input logic [31:0] op);
        return (op >= OP_WRITE) && (op <= OP_RISE);
    endfunction

    task automatic load_tests();
        $readmemh("dv/soc_tests.txt", test_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && known_op(test_field(num_tests[5:0], 2'd0))) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            other_errors++;
            $display("No test lines could be read from dv/soc_tests.txt");
        end
    endtask

    //////////////////////////////////////////////////
    // Bus and scan drivers
    //////////////////////////////////////////////////

    task automatic bus_access(input logic we, input soc_pkg::addr_t addr,
                              input soc_pkg::data_t wdata, input soc_pkg::data_t exp_v,
                              input logic rise);
        master_req.stb   <= 1'b1;
        master_req.we    <= we;
        master_req.addr  <= addr;
        master_req.wdata <= wdata;
        exp_data         <= exp_v;
        exp_rise         <= rise;
        access_count++;
        // Held until the ack edge
        do begin
            @(posedge clk50);
        end while (!master_rsp.ack);
        master_req.stb <= 1'b0;
    endtask

    task automatic scan_check(input logic [SCAN_W-1:0] idx, input soc_pkg::data_t exp_v);
        scan_addr <= idx;
        // Scan register loads on this edge
        @(posedge clk50);
        exp_data <= exp_v;
        scan_chk <= 1'b1;
        @(posedge clk50);
        scan_chk <= 1'b0;
    endtask

    task automatic run_tests();
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_v;
        int unsigned gap;
        for (int n = 0; n < num_tests; n++) begin
            op    = test_field(n[5:0], 2'd0);
            addr  = test_field(n[5:0], 2'd1);
            wdata = test_field(n[5:0], 2'd2);
            exp_v = test_field(n[5:0], 2'd3);
            gap   = $urandom % 4;
            repeat (gap) @(posedge clk50);
            case (op)
                OP_WRITE: bus_access(1'b1, addr[15:0], wdata, exp_v, 1'b0);
                OP_READ:  bus_access(1'b0, addr[15:0], wdata, exp_v, 1'b0);
                OP_RISE:  bus_access(1'b0, addr[15:0], wdata, exp_v, 1'b1);
                OP_SCAN:  scan_check(addr[SCAN_W-1:0], exp_v);
            endcase
        end
    endtask

    //////////////////////////////////////////////////
    // End of run
    //////////////////////////////////////////////////

    task automatic finish_run();
        int assert_errors;
        int total;
        assert_errors = UUT.u_intercon.u_assert.assert_errors;
        total = mismatch_count + spurious_count + assert_errors + timeout_count + other_errors;
        $display("Errors: %0d mismatch, %0d spurious ack, %0d assertion, %0d timeout, %0d other",
                 mismatch_count, spurious_count, assert_errors, timeout_count, other_errors);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        seed          = $urandom(95455);
        arst_n        = 1'b0;
        master_req    = '0;
        scan_addr     = '0;
        exp_data      = '0;
        exp_rise      = 1'b0;
        scan_chk      = 1'b0;
        access_count  = 0;
        timeout_count = 0;
        other_errors  = 0;
        tests_loaded  = 1'b0;
        load_tests();
        tests_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk50);
        arst_n <= 1'b1;
        run_tests();
        // Room for a late or extra ack
        repeat (3) @(posedge clk50);
        if (ack_count != access_count) begin
            other_errors++;
            $display("Saw %0d acks for %0d bus accesses", ack_count, access_count);
        end
        finish_run();
    end

    // Watchdog
    initial begin
        wait (tests_loaded === 1'b1);
        repeat (num_tests * CYCLES_PER_TEST + RESET_CYCLES) @(posedge clk50);
        timeout_count++;
        $display("Timeout at time %0t, the tests did not finish in time", $time);
        finish_run();
    end

endmodule

/* dv/soc_tests.txt */
// op addr wdata expect, hex; op 1 write, 2 read, 3 scan (addr is a word index)
// op 4 reads the counter: at least expect and above the previous op 4 read; op 0 ends
1 0000 11111111 00000000
2 0000 00000000 11111111
1 0ffc cafef00d 00000000
2 0ffc 00000000 cafef00d
1 1010 0badc0de 00000000
2 1010 00000000 0badc0de
3 0004 00000000 0badc0de
1 2000 0000a5a5 00000000
2 2000 00000000 0000a5a5
2 2004 00000000 00000000
1 2000 00000100 00000000
1 2004 00000001 00000000
2 2004 00000000 00000001
4 2000 00000000 00000100
2 3000 00000000 deadbeef
1 3000 55555555 00000000
2 0000 00000000 11111111
1 1ffc 13572468 00000000
2 0ffc 00000000 cafef00d
3 03ff 00000000 13572468
2 1ffc 00000000 13572468
2 f004 00000000 deadbeef
4 2000 00000000 00000100
0 0 0 0

/* filelist.f */
hdl/soc_pkg.sv
hdl/wb_intercon.sv
hdl/wb_ram.sv
hdl/vram_dual.sv
hdl/tick_counter.sv
hdl/simple_soc.sv
dv/soc_assert.sv
dv/soc_checker.sv
dv/tb_simple_soc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SoC testbench with Verilator

set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir \
    && verilator --binary --assert --top-module tb_simple_soc -f filelist.f \
        -o Vtb_simple_soc \
    && ./obj_dir/Vtb_simple_soc +verilator+error+limit+100 2>&1 | tee "$LOG" \
    || { echo "Build or simulation run did not complete"; exit 1; }

grep -q "Test failed" "$LOG" \
    && { echo "Simulation reported errors, see $LOG"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
